// File: hw/kl10Defs_defs.svh
`ifndef KL10DEFS_DEFS_SVH
`define KL10DEFS_DEFS_SVH

// CRAM geometry
`define CRAM_AW 9      // CRAM address and microPC width
`define CRAM_DW 36     // Full CRAM word as loaded over the bus

// Diagnostic bus
`define DS_W 7         // Diagnostic select code, group in upper 4 bits

// Clock control
`define BURST_W 9      // Burst count, taken from data bits 8..0

`endif

// File: hw/kl10Pkg.sv
`default_nettype none

`include "kl10Defs_defs.svh"

package kl10Pkg;

  // Upper 4 bits of the diagnostic select
  typedef enum logic [`DS_W-4:0] {
    DIAG_CLK  = 4'd0,    // Clock control functions
    DIAG_CRAM = 4'd1     // CRAM loading
  } diagGroupT;

  // Lower 3 bits of the select, group 0
  typedef enum logic [2:0] {
    CLK_STOP      = 3'd0,
    CLK_START     = 3'd1,
    CLK_STEP      = 3'd2,  // One microinstruction
    CLK_BURST     = 3'd4,  // Count comes from data
    CLK_CLR_RESET = 3'd6,
    CLK_SET_RESET = 3'd7
  } clkFuncT;

  // Lower 3 bits of the select, group 1
  typedef enum logic [2:0] {
    CRAM_LOAD_ADDR = 3'd0, // Set load pointer
    CRAM_WRITE     = 3'd1  // Write word, bump pointer
  } cramFuncT;

  // One microinstruction
  typedef struct packed {
    logic [`CRAM_DW-`CRAM_AW-1:0] ctl; // Control fields, opaque here
    logic [`CRAM_AW-1:0]          j;   // Next address
  } cramWordT;

endpackage

`default_nettype wire

// File: hw/ebusIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl10Defs_defs.svh"

interface ebusIf import kl10Pkg::*; ();

  logic [`DS_W-1:0]    ds;          // Diagnostic select
  logic [`CRAM_DW-1:0] data;        // Diagnostic data word
  logic                diagStrobe;  // Plain level from the front end

  // Decoded function pulses, one cycle wide
  clkFuncT             clkFunc;
  logic                clkGo;
  cramFuncT            cramFunc;
  logic                cramGo;

  // Front end side, driven at the top level
  modport front (output ds, output data, output diagStrobe);

  // Decoder
  modport dec (
    input  ds, input diagStrobe,
    output clkFunc, output clkGo, output cramFunc, output cramGo
  );

  // Function consumers: clock control and microsequencer
  modport user (input clkFunc, input clkGo, input cramFunc, input cramGo, input data);

endinterface

`default_nettype wire

// File: hw/cramStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl10Defs_defs.svh"

module cramStore import kl10Pkg::*; (
  input  logic                masterClk,
  input  logic                we,
  input  logic [`CRAM_AW-1:0] wAddr,
  input  cramWordT            wData,
  input  logic [`CRAM_AW-1:0] rAddr,
  output cramWordT            rData
);

  localparam int Depth = 1 << `CRAM_AW;   // 512 words

  cramWordT mem [Depth];

  // Empty control store at time zero
  initial begin
    for (int a = 0; a < Depth; a++) begin
      mem[a] = '0;
    end
  end

  always_ff @(posedge masterClk) begin
    if (we) begin
      mem[wAddr] <= wData;
    end
    rData <= mem[rAddr];   // Old word on a same-address write
  end

endmodule

`default_nettype wire

// File: hw/diagDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl10Defs_defs.svh"

module diagDecode import kl10Pkg::*; (
  input  logic masterClk,
  input  logic rstN,
  ebusIf.dec   bus
);

  logic            strobeQ;     // Strobe seen last cycle
  logic            strobeRise;
  logic [`DS_W-4:0] group;
  logic [2:0]      func;
  logic            isClk;
  logic            isCram;

  // Split select into group and function
  assign group = bus.ds[`DS_W-1:3];
  assign func  = bus.ds[2:0];

  // Only the first sample of a high strobe counts
  assign strobeRise = bus.diagStrobe & ~strobeQ;

  assign isClk  = (group == DIAG_CLK);
  assign isCram = (group == DIAG_CRAM);   // Anything else falls through

  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      strobeQ <= 1'b0;
    end else begin
      strobeQ <= bus.diagStrobe;
    end
  end

  // Pulse registers, one cycle after the sampling edge
  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      bus.clkGo    <= 1'b0;
      bus.cramGo   <= 1'b0;
      bus.clkFunc  <= CLK_STOP;
      bus.cramFunc <= CRAM_LOAD_ADDR;
    end else begin
      bus.clkGo  <= strobeRise & isClk;
      bus.cramGo <= strobeRise & isCram;
      if (strobeRise) begin
        // Unassigned codes still pass, consumers drop them
        bus.clkFunc  <= clkFuncT'(func);
        bus.cramFunc <= cramFuncT'(func);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/clkControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl10Defs_defs.svh"

module clkControl import kl10Pkg::*; (
  input  logic masterClk,
  input  logic rstN,
  ebusIf.user  bus,
  output logic mrReset,
  output logic advance
);

  logic                mrResetQ;   // Master reset, up at power on
  logic                runQ;       // Free running
  logic                stepQ;      // One step pending
  logic [`BURST_W-1:0] burstCnt;   // Burst cycles left
  logic                burstBusy;

  assign burstBusy = (burstCnt != '0);

  // Sequencer moves when any source asks and reset is off
  assign advance = ~mrResetQ & (runQ | stepQ | burstBusy);
  assign mrReset = mrResetQ;

  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      mrResetQ <= 1'b1;          // Come up in reset, like a crowbar
      runQ     <= 1'b0;
      stepQ    <= 1'b0;
      burstCnt <= '0;
    end else begin
      // Step and burst drain only when not free running
      if (!runQ) begin
        stepQ <= 1'b0;
        if (burstBusy) begin
          burstCnt <= burstCnt - 1'b1;
        end
      end

      // A new function overrides whatever is draining
      if (bus.clkGo) begin
        case (bus.clkFunc)
          CLK_STOP: begin
            runQ     <= 1'b0;
            burstCnt <= '0;
          end
          CLK_START: runQ <= 1'b1;
          CLK_STEP:  stepQ <= 1'b1;                            // Exactly one cycle
          CLK_BURST: burstCnt <= bus.data[`BURST_W-1:0];     // Zero gives nothing
          CLK_CLR_RESET: mrResetQ <= 1'b0;
          CLK_SET_RESET: begin
            mrResetQ <= 1'b1;
            runQ     <= 1'b0;
          end
          default: ;                 // Codes 3 and 5 do nothing
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/microSeq.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl10Defs_defs.svh"

module microSeq import kl10Pkg::*; (
  input  logic                masterClk,
  input  logic                rstN,
  ebusIf.user                 bus,
  input  logic                mrReset,
  input  logic                advance,
  output logic [`CRAM_AW-1:0] upc,
  output cramWordT            cramData
);

  logic [`CRAM_AW-1:0] pc;       // Microprogram counter
  logic [`CRAM_AW-1:0] wPtr;     // Load pointer
  logic [`CRAM_AW-1:0] rAddr;
  logic                we;
  logic                ldAddr;
  cramWordT            curWord;  // Word at pc, one in flight
  cramWordT            wData;

  // Read ahead on the jump target so the word lines up with the new pc
  always_comb begin
    if (mrReset) begin
      rAddr = '0;
    end else if (advance) begin
      rAddr = curWord.j;
    end else begin
      rAddr = pc;
    end
  end

  // Loading over the bus
  assign ldAddr = bus.cramGo & (bus.cramFunc == CRAM_LOAD_ADDR);
  assign we     = bus.cramGo & (bus.cramFunc == CRAM_WRITE);
  assign wData  = cramWordT'(bus.data);

  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (mrReset) begin
      pc <= '0;            // Held at zero in reset
    end else if (advance) begin
      pc <= curWord.j;
    end
  end

  always_ff @(posedge masterClk) begin
    if (!rstN) begin
      wPtr <= '0;
    end else if (ldAddr) begin
      wPtr <= bus.data[`CRAM_AW-1:0];
    end else if (we) begin
      wPtr <= wPtr + 1'b1;   // Next consecutive word
    end
  end

  cramStore cramInst (
    .masterClk (masterClk),
    .we        (we),
    .wAddr     (wPtr),
    .wData     (wData),
    .rAddr     (rAddr),
    .rData     (curWord)
  );

  assign upc      = pc;
  assign cramData = curWord;

endmodule

`default_nettype wire

// File: hw/kl10ClkTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl10Defs_defs.svh"

module kl10ClkTop (
  input  logic                masterClk,
  input  logic                rstN,
  input  logic [`DS_W-1:0]    ds,
  input  logic [`CRAM_DW-1:0] data,
  input  logic                diagStrobe,
  output logic                mrReset,
  output logic                eboxRun,
  output logic [`CRAM_AW-1:0] upc,
  output logic [`CRAM_DW-1:0] cramData
);

  ebusIf bus ();

  // Front end pins onto the internal bus
  assign bus.ds         = ds;
  assign bus.data       = data;
  assign bus.diagStrobe = diagStrobe;

  diagDecode decodeInst (
    .masterClk (masterClk),
    .rstN      (rstN),
    .bus       (bus.dec)
  );

  // eboxRun is the per-cycle advance enable
  clkControl clkInst (
    .masterClk (masterClk),
    .rstN      (rstN),
    .bus       (bus.user),
    .mrReset   (mrReset),
    .advance   (eboxRun)
  );

  microSeq seqInst (
    .masterClk (masterClk),
    .rstN      (rstN),
    .bus       (bus.user),
    .mrReset   (mrReset),
    .advance   (eboxRun),
    .upc       (upc),
    .cramData  (cramData)
  );

endmodule

`default_nettype wire

// File: dv/kl10ClkAsserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl10Defs_defs.svh"

module kl10ClkAsserts import kl10Pkg::*; (
  input logic                masterClk,
  input logic                rstN,
  input logic [`DS_W-1:0]    ds,
  input logic [`CRAM_DW-1:0] data,
  input logic                diagStrobe,
  input logic                mrReset,
  input logic                eboxRun,
  input logic [`CRAM_AW-1:0] upc,
  input logic [`CRAM_DW-1:0] cramData
);

  localparam int Depth = 1 << `CRAM_AW;

  logic                strobeSeen;   // Strobe level last cycle
  logic                actGo;        // Function takes effect next edge
  logic [`DS_W-1:0]    actDs;
  logic [`CRAM_DW-1:0] actData;
  logic                refReset;
  logic                refRun;
  logic                refStep;
  logic [`BURST_W-1:0] refBurst;     // Burst cycles still owed
  logic [`CRAM_AW-1:0] refPc;
  logic [`CRAM_AW-1:0] refPtr;
  logic                refWrote;     // Word output may lag one cycle
  logic                refAdvance;
  logic [`CRAM_AW-1:0] lastLink;     // Reference j field of the last cycle
  logic [`CRAM_DW-1:0] expWord;
  logic [`CRAM_DW-1:0] refMem [Depth];
  logic failReset = 1'b0;
  logic failRun   = 1'b0;
  logic failPc    = 1'b0;
  logic failWord  = 1'b0;
  logic failLink  = 1'b0;
  int   failCount;                   // Read by the testbench

  initial begin
    for (int a = 0; a < Depth; a++) begin
      refMem[a] = '0;
    end
  end

  assign refAdvance = ~refReset & (refRun | refStep | (refBurst != '0));
  assign expWord    = refMem[refPc];
  assign failCount  = $countones({failReset, failRun, failPc, failWord, failLink});

  always @(posedge masterClk) begin
    if (!rstN) begin
      strobeSeen <= 1'b0;
      actGo      <= 1'b0;
      refReset   <= 1'b1;   // Crowbar state
      refRun     <= 1'b0;
      refStep    <= 1'b0;
      refBurst   <= '0;
      refPc      <= '0;
      refPtr     <= '0;
      refWrote   <= 1'b0;
    end else begin
      strobeSeen <= diagStrobe;
      actGo      <= diagStrobe & ~strobeSeen & (ds[`DS_W-1:4] == '0); // Groups 0 and 1
      actDs      <= ds;
      actData    <= data;
      refWrote   <= 1'b0;
      if (refReset) begin
        refPc <= '0;
      end else if (refAdvance) begin
        refPc <= refMem[refPc][`CRAM_AW-1:0];   // Follow the chain
      end
      if (!refRun) begin
        refStep <= 1'b0;
        if (refBurst != '0) begin
          refBurst <= refBurst - 1'b1;
        end
      end
      if (actGo && !actDs[3]) begin
        case (actDs[2:0])
          CLK_STOP: begin
            refRun   <= 1'b0;
            refBurst <= '0;
          end
          CLK_START:     refRun   <= 1'b1;
          CLK_STEP:      refStep  <= 1'b1;
          CLK_BURST:     refBurst <= actData[`BURST_W-1:0];
          CLK_CLR_RESET: refReset <= 1'b0;
          CLK_SET_RESET: begin
            refReset <= 1'b1;
            refRun   <= 1'b0;
          end
          default: ;
        endcase
      end
      if (actGo && actDs[3] && actDs[2:0] == CRAM_LOAD_ADDR) begin
        refPtr <= actData[`CRAM_AW-1:0];
      end
      if (actGo && actDs[3] && actDs[2:0] == CRAM_WRITE) begin
        refMem[refPtr] <= actData;
        refPtr         <= refPtr + 1'b1;
        refWrote       <= 1'b1;
      end
    end
  end

  always @(posedge masterClk) begin
    lastLink <= expWord[`CRAM_AW-1:0];
  end

  resetChk: assert property (@(posedge masterClk) disable iff (!rstN) mrReset == refReset)
    else begin
      failReset = 1'b1;
      $error("ERROR %0t: mrReset expected %0b", $time, $sampled(refReset));
    end

  runChk: assert property (@(posedge masterClk) disable iff (!rstN) eboxRun == refAdvance)
    else begin
      failRun = 1'b1;
      $error("ERROR %0t: eboxRun expected %0b", $time, $sampled(refAdvance));
    end

  pcChk: assert property (@(posedge masterClk) disable iff (!rstN) upc == refPc)
    else begin
      failPc = 1'b1;
      $error("ERROR %0t: upc expected %0d", $time, $sampled(refPc));
    end

  // Word at the PC except the cycle after a write
  wordChk: assert property (@(posedge masterClk) disable iff (!rstN)
                            !refWrote |-> cramData == expWord)
    else begin
      failWord = 1'b1;
      $error("ERROR %0t: cramData expected %h", $time, $sampled(expWord));
    end

  linkChk: assert property (@(posedge masterClk) disable iff (!rstN)
                            eboxRun |=> upc == lastLink)
    else begin
      failLink = 1'b1;
      $error("ERROR %0t: upc expected j field %0d", $time, $sampled(lastLink));
    end

endmodule

`default_nettype wire

// File: dv/kl10ClkTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "kl10Defs_defs.svh"

module kl10ClkTb import kl10Pkg::*; ();

  localparam int ResetCycles = 8;
  localparam int DiagCalls   = 36;          // doDiag calls in the sequence below
  localparam int DiagBudget  = 64;          // Cycles allowed per call
  localparam int BurstCycles = 5 + 12 + 3;
  localparam int RunCycles   = 20;
  localparam int Margin      = 200;
  localparam int WatchdogCycles =
    ResetCycles + DiagCalls * DiagBudget + BurstCycles + RunCycles + Margin;

  logic                masterClk;
  logic                rstN;
  logic [`DS_W-1:0]    ds;
  logic [`CRAM_DW-1:0] data;
  logic                diagStrobe;
  logic                mrReset;
  logic                eboxRun;
  logic [`CRAM_AW-1:0] upc;
  logic [`CRAM_DW-1:0] cramData;
  integer              seed;
  logic [`CRAM_AW-1:0] ring [8];            // Microcode loop, back to 0
  int                  failCount;

  kl10ClkTop kl10ClkTop_inst (
    .masterClk  (masterClk),
    .rstN       (rstN),
    .ds         (ds),
    .data       (data),
    .diagStrobe (diagStrobe),
    .mrReset    (mrReset),
    .eboxRun    (eboxRun),
    .upc        (upc),
    .cramData   (cramData)
  );

  bind kl10ClkTop kl10ClkAsserts checkInst (
    .masterClk  (masterClk),
    .rstN       (rstN),
    .ds         (ds),
    .data       (data),
    .diagStrobe (diagStrobe),
    .mrReset    (mrReset),
    .eboxRun    (eboxRun),
    .upc        (upc),
    .cramData   (cramData)
  );

  assign failCount = kl10ClkTop_inst.checkInst.failCount;

  always #50 masterClk = ~masterClk;        // 100 ns period

  // Next address for a word, ring members link onward
  function automatic logic [`CRAM_AW-1:0] linkOf(input logic [`CRAM_AW-1:0] addr);
    logic [`CRAM_AW-1:0] res;
    res = addr + 1'b1;                      // Off the ring, never executed
    for (int i = 0; i < 8; i++) begin
      if (ring[i] == addr) begin
        res = ring[(i + 1) % 8];
      end
    end
    return res;
  endfunction

  function automatic logic [`CRAM_DW-1:0] addrWord(input logic [`CRAM_AW-1:0] addr);
    logic [`CRAM_DW-1:0] w;
    w = '0;
    w[`CRAM_AW-1:0] = addr;
    return w;
  endfunction

  // Front end sequence: select and data, strobe up 3 cycles, down 3
  task automatic doDiag(input logic [3:0] group, input logic [2:0] func,
                        input logic [`CRAM_DW-1:0] dataWord);
    @(negedge masterClk);
    ds         = {group, func};
    data       = dataWord;
    diagStrobe = 1'b1;
    repeat (3) @(negedge masterClk);
    diagStrobe = 1'b0;
    repeat (3) @(negedge masterClk);
  endtask

  // Random ctl bits on top of the chain link
  task automatic writeWord(input logic [`CRAM_AW-1:0] addr);
    logic [31:0] rnd;
    rnd = $random(seed);
    doDiag(DIAG_CRAM, CRAM_WRITE, {rnd[`CRAM_DW-`CRAM_AW-1:0], linkOf(addr)});
  endtask

  task automatic waitIdle();
    while (eboxRun) begin
      @(negedge masterClk);                 // Burst still draining
    end
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge masterClk);
    $display("Watchdog expired after %0d cycles, sequence did not finish", WatchdogCycles);
    $display("Test failed");
    $fatal(1, "Simulation stopped by the watchdog");
  end

  // First assertion failure ends the run
  always @(negedge masterClk) begin
    if (failCount != 0) begin
      $display("Test failed");
      $fatal(1, "Assertion check failed, see the ERROR line above");
    end
  end

  initial begin
    masterClk  = 1'b0;
    rstN       = 1'b0;
    ds         = '0;
    data       = '0;
    diagStrobe = 1'b0;
    seed       = 26;
    ring       = '{9'd0, 9'd5, 9'd9, 9'd14, 9'd23, 9'd31, 9'd40, 9'd47};
    repeat (ResetCycles) @(negedge masterClk);
    rstN = 1'b1;
    repeat (4) @(negedge masterClk);        // Powered up in reset, upc at 0

    // Consecutive words 0..9, then the rest of the ring one by one
    doDiag(DIAG_CRAM, CRAM_LOAD_ADDR, '0);
    for (int a = 0; a < 10; a++) begin
      writeWord(a[`CRAM_AW-1:0]);
    end
    for (int i = 3; i < 8; i++) begin
      doDiag(DIAG_CRAM, CRAM_LOAD_ADDR, addrWord(ring[i]));
      writeWord(ring[i]);
    end

    doDiag(DIAG_CLK, CLK_CLR_RESET, '0);

    // Codes that must change nothing
    doDiag(4'd2, CLK_START, '0);            // Group 2
    doDiag(DIAG_CLK, 3'd3, '0);
    doDiag(DIAG_CLK, 3'd5, '0);

    repeat (3) doDiag(DIAG_CLK, CLK_STEP, '0);

    doDiag(DIAG_CLK, CLK_BURST, '0);        // Zero length
    doDiag(DIAG_CLK, CLK_BURST, addrWord(9'd5));
    waitIdle();
    doDiag(DIAG_CLK, CLK_BURST, addrWord(9'd12));  // Wraps the ring
    waitIdle();

    doDiag(DIAG_CLK, CLK_START, '0);
    repeat (RunCycles) @(negedge masterClk);
    doDiag(DIAG_CLK, CLK_STOP, '0);

    // Reset while running, then a burst that reset holds off
    doDiag(DIAG_CLK, CLK_START, '0);
    doDiag(DIAG_CLK, CLK_SET_RESET, '0);
    doDiag(DIAG_CLK, CLK_BURST, addrWord(9'd3));
    repeat (8) @(negedge masterClk);

    if (failCount == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "Assertion checks reported errors");
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/kl10Pkg.sv
hw/ebusIf.sv
hw/cramStore.sv
hw/diagDecode.sv
hw/clkControl.sv
hw/microSeq.sv
hw/kl10ClkTop.sv
dv/kl10ClkAsserts.sv
dv/kl10ClkTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the KL10 clock-control testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=kl10ClkTb

verilator --binary --assert -j 0 --top-module "$TOP" --Mdir "$BUILD_DIR" -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Assertion errors are counted by the testbench, so let the run continue past them
"./$BUILD_DIR/V$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
